// File: Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing -j 0
TOP      := Cpu6502ExecTb
FILELIST := sources.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) verif/Cpu6502TbVectors.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: logic/Cpu6502Alu.sv
/* 6502 arithmetic and logic unit */
module Cpu6502Alu (
    input  Cpu6502Pkg::byte_t     operandA,
    input  Cpu6502Pkg::byte_t     operandB,
    input  logic                  carryIn,
    input  logic                  overflowIn,
    input  logic                  decimalMode,
    input  Cpu6502Pkg::aluOp_t    operation,
    input  logic [2:0]            opExtension,
    output Cpu6502Pkg::byte_t     result,
    output Cpu6502Pkg::aluFlags_t flags
);
    import Cpu6502Pkg::*;

    logic       subtract;
    logic       withCarry;
    logic       decimalAdj;
    logic       adderCarryIn;
    byte_t      addend2;
    logic [4:0] rawSumL;
    logic [4:0] rawSumH;
    logic       halfCarry;
    logic       fullCarry;
    byte_t      finalSum;
    logic       adderOverflow;
    logic       negFromB;

    // Adds 6 to a nibble after a decimal carry on add, or 10 (which is -6) after a
    // borrow on subtract
    function automatic logic [3:0] bcdAdjust(
        input logic [3:0] rawNibble,
        input logic       nibbleCarry,
        input logic       enable,
        input logic       isSub
    );
        logic [3:0] adjusted;
        adjusted = rawNibble;
        if (enable && !isSub && nibbleCarry) begin
            adjusted = rawNibble + 4'd6;
        end else if (enable && isSub && !nibbleCarry) begin
            adjusted = rawNibble + 4'd10;
        end
        return adjusted;
    endfunction

    assign subtract   = operation inside {ALU_OP_SBC, ALU_OP_SUB, ALU_OP_CMP};
    assign withCarry  = (operation == ALU_OP_ADC) || (operation == ALU_OP_SBC);
    assign decimalAdj = decimalMode & withCarry;

    // ADD adds nothing extra, while SUB and CMP add one so that they give a true A - B
    assign adderCarryIn = withCarry ? carryIn :
                          ((operation == ALU_OP_SUB) || (operation == ALU_OP_CMP));

    assign addend2 = subtract ? ~operandB : operandB;

    // The nibble adders chain through a carry that also fires on a decimal digit above 9
    assign rawSumL   = {1'b0, operandA[3:0]} + {1'b0, addend2[3:0]} + {4'd0, adderCarryIn};
    assign halfCarry = rawSumL[4] | (decimalAdj & ~subtract & (rawSumL[3:0] > 4'd9));
    assign rawSumH   = {1'b0, operandA[7:4]} + {1'b0, addend2[7:4]} + {4'd0, halfCarry};
    assign fullCarry = rawSumH[4] | (decimalAdj & ~subtract & (rawSumH[3:0] > 4'd9));

    assign finalSum = {bcdAdjust(rawSumH[3:0], fullCarry, decimalAdj, subtract),
                       bcdAdjust(rawSumL[3:0], halfCarry, decimalAdj, subtract)};

    // Carry into bit 7 differs from carry out of bit 7
    assign adderOverflow = operandA[7] ^ addend2[7] ^ rawSumH[3] ^ rawSumH[4];

    always_comb begin
        result                = '0;
        flags.carry           = carryIn;
        flags.overflow        = overflowIn;
        flags.branchCondition = 1'b0;
        negFromB              = 1'b0;

        case (operation)
            ALU_OP_AND: result = operandA & operandB;
            ALU_OP_OR:  result = operandA | operandB;
            ALU_OP_EOR: result = operandA ^ operandB;
            ALU_OP_ADC, ALU_OP_SBC: begin
                result                = finalSum;
                flags.carry           = fullCarry;
                flags.overflow        = adderOverflow;
                flags.branchCondition = fullCarry;
            end
            ALU_OP_ADD, ALU_OP_SUB: begin
                // Address style arithmetic whose carry only reaches the branch condition
                result                = finalSum;
                flags.branchCondition = fullCarry;
            end
            ALU_OP_BIT: begin
                result         = operandA & operandB;
                flags.overflow = operandB[6];
                negFromB       = 1'b1;
            end
            ALU_OP_CMP: begin
                result      = finalSum;
                flags.carry = fullCarry;
                negFromB    = 1'b1;
            end
            ALU_OP_SETBIT: result = operandA | (8'd1 << opExtension);
            ALU_OP_CLRBIT: result = operandA & ~(8'd1 << opExtension);
            ALU_OP_SGL: begin
                case (aluSop_t'(opExtension))
                    ALU_SOP_ASL: begin
                        result      = {operandA[6:0], 1'b0};
                        flags.carry = operandA[7];
                    end
                    ALU_SOP_LSR: begin
                        result      = {1'b0, operandA[7:1]};
                        flags.carry = operandA[0];
                    end
                    ALU_SOP_ROL: begin
                        result      = {operandA[6:0], carryIn};
                        flags.carry = operandA[7];
                    end
                    ALU_SOP_ROR: begin
                        result      = {carryIn, operandA[7:1]};
                        flags.carry = operandA[0];
                    end
                    // Tests pass operand A through and pick one of its P bits
                    ALU_SOP_TEST_N: begin
                        result                = operandA;
                        flags.branchCondition = operandA[N_BIT_IN_P];
                    end
                    ALU_SOP_TEST_C: begin
                        result                = operandA;
                        flags.branchCondition = operandA[C_BIT_IN_P];
                    end
                    ALU_SOP_TEST_V: begin
                        result                = operandA;
                        flags.branchCondition = operandA[V_BIT_IN_P];
                    end
                    ALU_SOP_TEST_Z: begin
                        result                = operandA;
                        flags.branchCondition = operandA[Z_BIT_IN_P];
                    end
                    default: result = '0;
                endcase
            end
            default: result = '0;
        endcase

        flags.zero     = ~|result;
        flags.negative = negFromB ? operandB[7] : result[7];
    end

endmodule

// File: logic/Cpu6502ExecUnit.sv
/* 6502 execute datapath */
module Cpu6502ExecUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 execute,
    input  Cpu6502Pkg::microOp_t uop,
    input  Cpu6502Pkg::byte_t    dataIn,
    output Cpu6502Pkg::byte_t    regA,
    output Cpu6502Pkg::byte_t    regX,
    output Cpu6502Pkg::byte_t    regY,
    output Cpu6502Pkg::byte_t    regP,
    output logic                 branchTaken
);
    import Cpu6502Pkg::*;

    byte_t     operandA;
    byte_t     aluResult;
    aluFlags_t aluFlags;

    Cpu6502RegFile regFile (
        .clk      (clk),
        .rstN     (rstN),
        .execute  (execute),
        .srcA     (uop.srcA),
        .dest     (uop.dest),
        .result   (aluResult),
        .regP     (regP),
        .operandA (operandA),
        .regA     (regA),
        .regX     (regX),
        .regY     (regY)
    );

    Cpu6502StatusReg statusReg (
        .clk      (clk),
        .rstN     (rstN),
        .execute  (execute),
        .dest     (uop.dest),
        .flagMask (uop.flagMask),
        .result   (aluResult),
        .flags    (aluFlags),
        .regP     (regP)
    );

    // Carry, overflow and decimal mode come straight from the current P
    Cpu6502Alu alu (
        .operandA    (operandA),
        .operandB    (dataIn),
        .carryIn     (regP[C_BIT_IN_P]),
        .overflowIn  (regP[V_BIT_IN_P]),
        .decimalMode (regP[D_BIT_IN_P]),
        .operation   (uop.aluOp),
        .opExtension (uop.opExt),
        .result      (aluResult),
        .flags       (aluFlags)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            branchTaken <= 1'b0;
        end else if (execute) begin
            branchTaken <= aluFlags.branchCondition;
        end
    end

endmodule

// File: logic/Cpu6502Pkg.sv
/* 6502 execute datapath types */
package Cpu6502Pkg;

    // Data byte carried by registers, operands and the ALU result
    typedef logic [7:0] byte_t;

    typedef enum logic [3:0] {
        ALU_OP_AND    = 4'd0,
        ALU_OP_OR     = 4'd1,
        ALU_OP_EOR    = 4'd2,
        ALU_OP_ADC    = 4'd3,
        ALU_OP_SBC    = 4'd4,
        ALU_OP_ADD    = 4'd5,
        ALU_OP_SUB    = 4'd6,
        ALU_OP_BIT    = 4'd7,
        ALU_OP_CMP    = 4'd8,
        ALU_OP_SETBIT = 4'd9,
        ALU_OP_CLRBIT = 4'd10,
        ALU_OP_SGL    = 4'd11
    } aluOp_t;

    // Single operand operations, selected by the extension field of ALU_OP_SGL
    typedef enum logic [2:0] {
        ALU_SOP_ASL    = 3'd0,
        ALU_SOP_LSR    = 3'd1,
        ALU_SOP_ROL    = 3'd2,
        ALU_SOP_ROR    = 3'd3,
        ALU_SOP_TEST_N = 3'd4,
        ALU_SOP_TEST_C = 3'd5,
        ALU_SOP_TEST_V = 3'd6,
        ALU_SOP_TEST_Z = 3'd7
    } aluSop_t;

    typedef enum logic [1:0] {
        REG_A = 2'd0,
        REG_X = 2'd1,
        REG_Y = 2'd2,
        REG_P = 2'd3
    } regSel_t;

    typedef enum logic [2:0] {
        DEST_NONE = 3'd0,
        DEST_A    = 3'd1,
        DEST_X    = 3'd2,
        DEST_Y    = 3'd3,
        DEST_P    = 3'd4
    } destSel_t;

    typedef struct packed {
        logic updNZ;
        logic updC;
        logic updV;
    } flagMask_t;

    typedef struct packed {
        aluOp_t     aluOp;
        logic [2:0] opExt;
        regSel_t    srcA;
        destSel_t   dest;
        flagMask_t  flagMask;
    } microOp_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic overflow;
        logic branchCondition;
    } aluFlags_t;

    localparam int unsigned C_BIT_IN_P = 0;
    localparam int unsigned Z_BIT_IN_P = 1;
    localparam int unsigned I_BIT_IN_P = 2;
    localparam int unsigned D_BIT_IN_P = 3;
    // Bit 5 has no function and always reads as one
    localparam int unsigned U_BIT_IN_P = 5;
    localparam int unsigned V_BIT_IN_P = 6;
    localparam int unsigned N_BIT_IN_P = 7;

    localparam byte_t P_RESET = 8'h20;

endpackage

// File: logic/Cpu6502RegFile.sv
/* A, X and Y registers */
module Cpu6502RegFile (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 execute,
    input  Cpu6502Pkg::regSel_t  srcA,
    input  Cpu6502Pkg::destSel_t dest,
    input  Cpu6502Pkg::byte_t    result,
    input  Cpu6502Pkg::byte_t    regP,
    output Cpu6502Pkg::byte_t    operandA,
    output Cpu6502Pkg::byte_t    regA,
    output Cpu6502Pkg::byte_t    regX,
    output Cpu6502Pkg::byte_t    regY
);
    import Cpu6502Pkg::*;

    // Operand A source mux, where P comes from the status register
    always_comb begin
        case (srcA)
            REG_A:   operandA = regA;
            REG_X:   operandA = regX;
            REG_Y:   operandA = regY;
            REG_P:   operandA = regP;
            default: operandA = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regA <= '0;
            regX <= '0;
            regY <= '0;
        end else if (execute) begin
            case (dest)
                DEST_A: regA <= result;
                DEST_X: regX <= result;
                DEST_Y: regY <= result;
                // DEST_P and DEST_NONE leave the working registers alone
                default: begin
                    regA <= regA;
                    regX <= regX;
                    regY <= regY;
                end
            endcase
        end
    end

endmodule

// File: logic/Cpu6502StatusReg.sv
/* Processor status register */
module Cpu6502StatusReg (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  execute,
    input  Cpu6502Pkg::destSel_t  dest,
    input  Cpu6502Pkg::flagMask_t flagMask,
    input  Cpu6502Pkg::byte_t     result,
    input  Cpu6502Pkg::aluFlags_t flags,
    output Cpu6502Pkg::byte_t     regP
);
    import Cpu6502Pkg::*;

    byte_t pNext;

    always_comb begin
        pNext = regP;

        if (dest == DEST_P) begin
            // A whole byte write is the only way to change I and D
            pNext             = result;
            pNext[U_BIT_IN_P] = 1'b1;
        end else begin
            if (flagMask.updNZ) begin
                pNext[N_BIT_IN_P] = flags.negative;
                pNext[Z_BIT_IN_P] = flags.zero;
            end
            if (flagMask.updC) begin
                pNext[C_BIT_IN_P] = flags.carry;
            end
            if (flagMask.updV) begin
                pNext[V_BIT_IN_P] = flags.overflow;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regP <= P_RESET;
        end else if (execute) begin
            regP <= pNext;
        end
    end

endmodule

// File: sources.f
+incdir+verif
logic/Cpu6502Pkg.sv
logic/Cpu6502Alu.sv
logic/Cpu6502RegFile.sv
logic/Cpu6502StatusReg.sv
logic/Cpu6502ExecUnit.sv
verif/Cpu6502ExecTb.sv

// File: verif/Cpu6502TbVectors.svh
/* Execute datapath test vectors */
`ifndef CPU6502_TB_VECTORS_SVH
`define CPU6502_TB_VECTORS_SVH

// Each row gives execute, ALU op, extension, operand A source, destination, flag groups and
// dataIn, then the expected {regA, regX, regY, regP} and branchTaken after the rising edge
task automatic loadVectors();
    // Held state out of reset, then loads through OR with a zero register
    addRow(0, ALU_OP_OR, 0, REG_A, DEST_A, NZ, 8'hFF, 32'h00_00_00_20, 0);
    addRow(1, ALU_OP_OR, 0, REG_A, DEST_A, NZ, 8'h80, 32'h80_00_00_A0, 0);
    addRow(1, ALU_OP_OR, 0, REG_X, DEST_X, NZ, 8'h00, 32'h80_00_00_22, 0);
    addRow(1, ALU_OP_OR, 0, REG_Y, DEST_Y, NZ, 8'h3C, 32'h80_00_3C_20, 0);
    addRow(1, ALU_OP_OR, 0, REG_X, DEST_A, NZ, 8'hF0, 32'hF0_00_3C_A0, 0);
    addRow(1, ALU_OP_AND, 0, REG_A, DEST_A, NZ, 8'h0F, 32'h00_00_3C_22, 0);
    addRow(1, ALU_OP_OR, 0, REG_A, DEST_A, NZ, 8'h5A, 32'h5A_00_3C_20, 0);
    addRow(1, ALU_OP_EOR, 0, REG_A, DEST_A, NZ, 8'hFF, 32'hA5_00_3C_A0, 0);
    // Zero result with every flag group masked, so N stays set
    addRow(1, ALU_OP_EOR, 0, REG_A, DEST_A, NO_FLAGS, 8'hA5, 32'h00_00_3C_A0, 0);

    // Binary add and subtract with carry and signed overflow
    addRow(1, ALU_OP_OR, 0, REG_A, DEST_A, NZ, 8'h50, 32'h50_00_3C_20, 0);
    addRow(1, ALU_OP_ADC, 0, REG_A, DEST_A, NZCV, 8'h50, 32'hA0_00_3C_E0, 0);
    addRow(1, ALU_OP_ADC, 0, REG_A, DEST_A, NZCV, 8'h70, 32'h10_00_3C_21, 1);
    addRow(1, ALU_OP_SBC, 0, REG_A, DEST_A, NZCV, 8'h20, 32'hF0_00_3C_A0, 0);
    addRow(1, ALU_OP_SBC, 0, REG_A, DEST_A, NZCV, 8'h7F, 32'h70_00_3C_61, 1);
    addRow(1, ALU_OP_CMP, 0, REG_A, DEST_NONE, NZC, 8'h70, 32'h70_00_3C_63, 0);
    // CMP takes N from the bus operand, here set while the difference 8'h7F is positive
    addRow(1, ALU_OP_CMP, 0, REG_A, DEST_NONE, NZC, 8'hF1, 32'h70_00_3C_E0, 0);
    // ADD and SUB keep C and V even with every group enabled
    addRow(1, ALU_OP_ADD, 0, REG_A, DEST_X, NZCV, 8'hC0, 32'h70_30_3C_60, 1);
    addRow(1, ALU_OP_SUB, 0, REG_X, DEST_Y, NZCV, 8'h40, 32'h70_30_F0_E0, 0);

    // Decimal mode on, BCD add and subtract, then decimal mode off
    addRow(1, ALU_OP_SETBIT, 3, REG_P, DEST_P, NO_FLAGS, 8'h00, 32'h70_30_F0_E8, 0);
    addRow(1, ALU_OP_EOR, 0, REG_A, DEST_A, NZ, 8'h69, 32'h19_30_F0_68, 0);
    addRow(1, ALU_OP_ADC, 0, REG_A, DEST_A, NZC, 8'h28, 32'h47_30_F0_68, 0);
    addRow(1, ALU_OP_ADC, 0, REG_A, DEST_A, NZC, 8'h58, 32'h05_30_F0_69, 1);
    addRow(1, ALU_OP_SBC, 0, REG_A, DEST_A, NZC, 8'h08, 32'h97_30_F0_E8, 0);
    addRow(1, ALU_OP_SBC, 0, REG_A, DEST_A, NZC, 8'h18, 32'h78_30_F0_69, 1);
    addRow(1, ALU_OP_CLRBIT, 3, REG_P, DEST_P, NO_FLAGS, 8'h00, 32'h78_30_F0_61, 0);

    // Shifts and rotates on A
    addRow(1, ALU_OP_SGL, ALU_SOP_ASL, REG_A, DEST_A, NZC, 8'h00, 32'hF0_30_F0_E0, 0);
    addRow(1, ALU_OP_SGL, ALU_SOP_ROL, REG_A, DEST_A, NZC, 8'h00, 32'hE0_30_F0_E1, 0);
    addRow(1, ALU_OP_SGL, ALU_SOP_ROL, REG_A, DEST_A, NZC, 8'h00, 32'hC1_30_F0_E1, 0);
    addRow(1, ALU_OP_SGL, ALU_SOP_ROR, REG_A, DEST_A, NZC, 8'h00, 32'hE0_30_F0_E1, 0);
    addRow(1, ALU_OP_SGL, ALU_SOP_LSR, REG_A, DEST_A, NZC, 8'h00, 32'h70_30_F0_60, 0);

    // BIT, single bit operations on X and flag tests on P
    addRow(1, ALU_OP_BIT, 0, REG_A, DEST_NONE, NZV, 8'h8F, 32'h70_30_F0_A2, 0);
    addRow(1, ALU_OP_BIT, 0, REG_A, DEST_NONE, NZV, 8'h40, 32'h70_30_F0_60, 0);
    addRow(1, ALU_OP_SETBIT, 7, REG_X, DEST_X, NO_FLAGS, 8'h00, 32'h70_B0_F0_60, 0);
    addRow(1, ALU_OP_CLRBIT, 4, REG_X, DEST_X, NO_FLAGS, 8'h00, 32'h70_A0_F0_60, 0);
    addRow(1, ALU_OP_SGL, ALU_SOP_TEST_V, REG_P, DEST_NONE, NO_FLAGS, 8'h00, 32'h70_A0_F0_60, 1);
    addRow(1, ALU_OP_SGL, ALU_SOP_TEST_C, REG_P, DEST_NONE, NO_FLAGS, 8'h00, 32'h70_A0_F0_60, 0);
    addRow(1, ALU_OP_AND, 0, REG_Y, DEST_NONE, NZ, 8'h0F, 32'h70_A0_F0_62, 0);
    addRow(1, ALU_OP_SGL, ALU_SOP_TEST_Z, REG_P, DEST_NONE, NO_FLAGS, 8'h00, 32'h70_A0_F0_62, 1);
    addRow(1, ALU_OP_CMP, 0, REG_A, DEST_NONE, NZC, 8'h80, 32'h70_A0_F0_E0, 0);
    addRow(1, ALU_OP_SGL, ALU_SOP_TEST_N, REG_P, DEST_NONE, NO_FLAGS, 8'h00, 32'h70_A0_F0_E0, 1);
    // Idle cycle holds branchTaken although TEST_C would clear it
    addRow(0, ALU_OP_SGL, ALU_SOP_TEST_C, REG_P, DEST_NONE, NO_FLAGS, 8'h00, 32'h70_A0_F0_E0, 1);
endtask

`endif

// File: verif/Cpu6502ExecTb.sv
/* 6502 execute datapath testbench */
module Cpu6502ExecTb;
    timeunit 1ns;
    timeprecision 100ps;

    import Cpu6502Pkg::*;

    localparam int CLK_HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 5;

    // Flag group enables in the order updNZ, updC, updV
    localparam flagMask_t NO_FLAGS = 3'b000;
    localparam flagMask_t NZ = 3'b100;
    localparam flagMask_t NZC = 3'b110;
    localparam flagMask_t NZV = 3'b101;
    localparam flagMask_t NZCV = 3'b111;

    typedef struct packed {
        logic        execute;
        microOp_t    uop;
        byte_t       dataIn;
        logic [31:0] expRegs;
        logic        expBranch;
    } vector_t;

    logic     clk;
    logic     rstN;
    logic     execute;
    microOp_t uop;
    byte_t    dataIn;
    byte_t    regA;
    byte_t    regX;
    byte_t    regY;
    byte_t    regP;
    logic     branchTaken;

    vector_t vectors[$];
    int      cycleCount;
    int      cycleLimit;

    Cpu6502ExecUnit DUT (
        .clk         (clk),
        .rstN        (rstN),
        .execute     (execute),
        .uop         (uop),
        .dataIn      (dataIn),
        .regA        (regA),
        .regX        (regX),
        .regY        (regY),
        .regP        (regP),
        .branchTaken (branchTaken)
    );

    always #CLK_HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles before the vector table was done", cycleCount);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic addRow(input logic exec, input aluOp_t op, input logic [2:0] ext,
                          input regSel_t src, input destSel_t dest, input flagMask_t mask,
                          input byte_t din, input logic [31:0] regs, input logic br);
        vector_t row;
        row.execute        = exec;
        row.uop.aluOp      = op;
        row.uop.opExt      = ext;
        row.uop.srcA       = src;
        row.uop.dest       = dest;
        row.uop.flagMask   = mask;
        row.dataIn         = din;
        row.expRegs        = regs;
        row.expBranch      = br;
        vectors.push_back(row);
    endtask

    task automatic checkValue(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s expected 8'h%02h, actual 8'h%02h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Expected registers are packed as {regA, regX, regY, regP}
    task automatic compareOutputs(input logic [31:0] regs, input logic br);
        checkValue("regA", regs[31:24], regA);
        checkValue("regX", regs[23:16], regX);
        checkValue("regY", regs[15:8], regY);
        checkValue("regP", regs[7:0], regP);
        checkValue("branchTaken", {7'd0, br}, {7'd0, branchTaken});
    endtask

    `include "Cpu6502TbVectors.svh"

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        execute    = 1'b0;
        uop        = '0;
        dataIn     = '0;
        cycleCount = 0;
        loadVectors();
        cycleLimit = RESET_CYCLES + 2 * vectors.size() + 20;

        repeat (RESET_CYCLES) @(negedge clk);
        // Only bit 5 of P is set out of reset
        compareOutputs({8'h00, 8'h00, 8'h00, 8'h20}, 1'b0);
        rstN = 1'b1;

        // Each row goes in on a falling edge and is checked one cycle later
        foreach (vectors[i]) begin
            execute = vectors[i].execute;
            uop     = vectors[i].uop;
            dataIn  = vectors[i].dataIn;
            @(negedge clk);
            compareOutputs(vectors[i].expRegs, vectors[i].expBranch);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
